// File: verilog/sdram_map_pkg.sv
package sdram_map_pkg;

    localparam int sdram_aw = 22;   // SDRAM word address width

    // Region offsets in SDRAM words
    localparam logic [sdram_aw-1:0] sound_offset = 22'h00_0000;
    localparam logic [sdram_aw-1:0] ram_offset   = 22'h20_0000;
    localparam logic [sdram_aw-1:0] vram_offset  = 22'h30_0000;
    localparam logic [sdram_aw-1:0] gfx_offset   = 22'h00_0000; // Bank 2

    // Bank per region
    localparam logic [1:0] bank_main  = 2'd1;   // CPU ROM, RAM and VRAM
    localparam logic [1:0] bank_sound = 2'd0;
    localparam logic [1:0] bank_gfx   = 2'd2;

    // Loader byte addresses where each region starts
    // Main CPU ROM sits below dl_sound_start
    localparam logic [24:0] dl_sound_start = 25'h40_0000;
    localparam logic [24:0] dl_gfx_start   = 25'h50_0000;

    // Slot indexes, lowest index wins
    localparam int slot_main_rom = 0;
    localparam int slot_main_ram = 1;
    localparam int slot_gfx      = 2;
    localparam int slot_sound    = 3;
    localparam int num_slots     = 4;

endpackage

// File: verilog/slot_request.sv
module slot_request import sdram_map_pkg::*; #(
    parameter int                  aw           = 16,
    parameter int                  dw           = 16,
    parameter logic [1:0]          bank         = bank_main,
    parameter logic [sdram_aw-1:0] offset       = '0,
    parameter bit                  use_vram_sel = 1'b0    // Main RAM slot only
) (
    input  logic                VB,
    input  logic                rst,
    input  logic                cs,
    input  logic [aw-1:0]       addr,
    input  logic                wr,
    input  logic [15:0]         din,
    input  logic [1:0]          wrmask,
    input  logic                vram_sel,
    output logic [dw-1:0]       dout,
    output logic                ok,
    output logic                pend,
    output logic [sdram_aw-1:0] full_addr,
    output logic [1:0]          bank_out,
    output logic                rnw,
    output logic [15:0]         wdata,
    output logic [1:0]          wmask,
    input  logic                grant_done,
    input  logic [31:0]         rdata
);

    logic                cs_l;
    logic [aw-1:0]       addr_l;
    logic                hit_valid;
    logic [sdram_aw-1:0] hit_addr;     // SDRAM address of the word held in dout
    logic [sdram_aw-1:0] region;
    logic [sdram_aw-1:0] req_addr;
    logic                addr_chg;
    logic                new_req;
    logic                hit;

    assign region   = (use_vram_sel && vram_sel) ? vram_offset : offset;
    assign req_addr = region + {{(sdram_aw - aw){1'b0}}, addr};
    assign addr_chg = addr != addr_l;
    assign new_req  = cs && (!cs_l || addr_chg) && !pend;
    assign hit      = !wr && hit_valid && req_addr == hit_addr;
    assign bank_out = bank;

    always_ff @(posedge VB) begin
        if (rst) begin
            cs_l      <= 1'b0;
            addr_l    <= '0;
            ok        <= 1'b0;
            pend      <= 1'b0;
            hit_valid <= 1'b0;
        end else begin
            cs_l   <= cs;
            addr_l <= addr;
            if (!cs || addr_chg) ok <= 1'b0;
            if (grant_done) begin
                pend      <= 1'b0;
                ok        <= cs && !addr_chg;
                hit_valid <= rnw;          // Writes invalidate the held word
            end else if (new_req) begin
                if (hit) ok <= 1'b1;       // One-word hit, no SDRAM access
                else pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge VB) begin
        if (new_req && !hit) begin
            full_addr <= req_addr;
            rnw       <= !wr;
            wdata     <= din;
            wmask     <= wr ? wrmask : 2'b11;
        end
        if (grant_done && rnw) begin
            dout     <= rdata[dw-1:0];
            hit_addr <= full_addr;
        end
    end

endmodule

// File: verilog/slot_arbiter.sv
module slot_arbiter import sdram_map_pkg::*; (
    input  logic                 VB,
    input  logic                 rst,
    input  logic                 downloading,
    input  logic [num_slots-1:0] pend,
    // Per-slot request fields, index matches pend
    input  logic [sdram_aw-1:0]  addr0,
    input  logic [sdram_aw-1:0]  addr1,
    input  logic [sdram_aw-1:0]  addr2,
    input  logic [sdram_aw-1:0]  addr3,
    input  logic [1:0]           bank0,
    input  logic [1:0]           bank1,
    input  logic [1:0]           bank2,
    input  logic [1:0]           bank3,
    input  logic                 rnw0,
    input  logic                 rnw1,
    input  logic                 rnw2,
    input  logic                 rnw3,
    input  logic [15:0]          wdata0,
    input  logic [15:0]          wdata1,
    input  logic [15:0]          wdata2,
    input  logic [15:0]          wdata3,
    input  logic [1:0]           wmask0,
    input  logic [1:0]           wmask1,
    input  logic [1:0]           wmask2,
    input  logic [1:0]           wmask3,
    output logic [num_slots-1:0] grant_done,
    output logic                 sdram_req,
    output logic [sdram_aw-1:0]  sdram_addr,
    output logic [1:0]           sdram_bank,
    output logic                 sdram_rnw,
    output logic [15:0]          data_write,
    output logic [1:0]           sdram_wrmask,
    input  logic                 sdram_ack,
    input  logic                 data_rdy
);

    localparam int sw = $clog2(num_slots);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_ack  = 2'd1;   // Waiting for sdram_ack
    localparam logic [1:0] st_data = 2'd2;   // Waiting for data_rdy

    logic [1:0]          state;
    logic [sw-1:0]       sel;
    logic [sw-1:0]       owner;      // Slot of the access in flight
    logic                start;
    logic [sdram_aw-1:0] addr_v  [num_slots];
    logic [1:0]          bank_v  [num_slots];
    logic [num_slots-1:0] rnw_v;
    logic [15:0]         wdata_v [num_slots];
    logic [1:0]          wmask_v [num_slots];

    assign addr_v  = '{addr0, addr1, addr2, addr3};
    assign bank_v  = '{bank0, bank1, bank2, bank3};
    assign rnw_v   = {rnw3, rnw2, rnw1, rnw0};
    assign wdata_v = '{wdata0, wdata1, wdata2, wdata3};
    assign wmask_v = '{wmask0, wmask1, wmask2, wmask3};

    // Lowest pending index wins
    always_comb begin
        sel = '0;
        for (int i = num_slots - 1; i >= 0; i--) begin
            if (pend[i]) sel = sw'(i);
        end
    end

    // No new slot access while the loader owns the SDRAM
    assign start = state == st_idle && !downloading && |pend;

    always_comb begin
        for (int i = 0; i < num_slots; i++) begin
            grant_done[i] = data_rdy && state == st_data && owner == sw'(i);
        end
    end

    always_ff @(posedge VB) begin
        if (rst) begin
            state     <= st_idle;
            sdram_req <= 1'b0;
            owner     <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state     <= st_ack;
                        sdram_req <= 1'b1;
                        owner     <= sel;
                    end
                end
                st_ack: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= st_data;
                    end
                end
                st_data: begin
                    if (data_rdy) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Request fields stay put until the next start
    always_ff @(posedge VB) begin
        if (start) begin
            sdram_addr   <= addr_v[sel];
            sdram_bank   <= bank_v[sel];
            sdram_rnw    <= rnw_v[sel];
            data_write   <= wdata_v[sel];
            sdram_wrmask <= wmask_v[sel];
        end
    end

endmodule

// File: verilog/rom_download.sv
module rom_download import sdram_map_pkg::*; (
    input  logic                VB,
    input  logic                rst,
    input  logic                downloading,
    input  logic [24:0]         ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  logic                ioctl_wr,
    input  logic                sdram_ack,
    output logic [sdram_aw-1:0] prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,
    output logic [1:0]          prog_bank,
    output logic                prog_we
);

    logic [24:0]         start;     // Byte address where the region begins
    logic [sdram_aw-1:0] region;
    logic [1:0]          bank_sel;
    logic [24:0]         rel;
    logic                take;

    always_comb begin
        if (ioctl_addr >= dl_gfx_start) begin
            start    = dl_gfx_start;
            region   = gfx_offset;
            bank_sel = bank_gfx;
        end else if (ioctl_addr >= dl_sound_start) begin
            start    = dl_sound_start;
            region   = sound_offset;
            bank_sel = bank_sound;
        end else begin
            start    = '0;          // Main CPU ROM at the bottom of bank 1
            region   = '0;
            bank_sel = bank_main;
        end
    end

    assign rel  = ioctl_addr - start;
    assign take = downloading && ioctl_wr && !prog_we;

    always_ff @(posedge VB) begin
        if (rst) prog_we <= 1'b0;
        else if (prog_we && sdram_ack) prog_we <= 1'b0;
        else if (take) prog_we <= 1'b1;
    end

    always_ff @(posedge VB) begin
        if (take) begin
            prog_addr <= region + rel[sdram_aw:1];          // Byte to word
            prog_data <= ioctl_data;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;    // Active low, odd is upper
            prog_bank <= bank_sel;
        end
    end

endmodule

// File: verilog/sdram_game_mux.sv
module sdram_game_mux import sdram_map_pkg::*; (
    input  logic                VB,
    input  logic                rst,
    input  logic                downloading,
    // Main CPU ROM
    input  logic                main_rom_cs,
    input  logic [20:0]         main_rom_addr,
    output logic [15:0]         main_rom_data,
    output logic                main_rom_ok,
    // Main CPU RAM and VRAM
    input  logic                main_ram_cs,
    input  logic                main_ram_vram,
    input  logic                main_ram_rnw,
    input  logic [16:0]         main_ram_addr,
    input  logic [15:0]         main_ram_din,
    input  logic [1:0]          main_ram_dsn,
    output logic [15:0]         main_ram_data,
    output logic                main_ram_ok,
    // Graphics ROM
    input  logic                gfx_cs,
    input  logic [19:0]         gfx_addr,
    output logic [31:0]         gfx_data,
    output logic                gfx_ok,
    // Sound ROM
    input  logic                snd_cs,
    input  logic [15:0]         snd_addr,
    output logic [7:0]          snd_data,
    output logic                snd_ok,
    // SDRAM
    output logic                sdram_req,
    output logic [sdram_aw-1:0] sdram_addr,
    output logic [1:0]          sdram_bank,
    output logic                sdram_rnw,
    output logic [15:0]         data_write,
    output logic [1:0]          sdram_wrmask,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  logic [31:0]         data_read,
    // ROM loader
    input  logic [24:0]         ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  logic                ioctl_wr,
    output logic [sdram_aw-1:0] prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,
    output logic [1:0]          prog_bank,
    output logic                prog_we
);

    logic [num_slots-1:0] pend;
    logic [num_slots-1:0] grant_done;
    logic [num_slots-1:0] slot_rnw;
    logic [sdram_aw-1:0]  slot_addr  [num_slots];
    logic [1:0]           slot_bank  [num_slots];
    logic [15:0]          slot_wdata [num_slots];
    logic [1:0]           slot_wmask [num_slots];

    slot_request #(.aw(21), .dw(16), .bank(bank_main), .offset('0)) u_main_rom (
        .VB(VB), .rst(rst), .cs(main_rom_cs), .addr(main_rom_addr),
        .wr(1'b0), .din(16'h0000), .wrmask(2'b11), .vram_sel(1'b0),
        .dout(main_rom_data), .ok(main_rom_ok), .pend(pend[slot_main_rom]),
        .full_addr(slot_addr[slot_main_rom]), .bank_out(slot_bank[slot_main_rom]),
        .rnw(slot_rnw[slot_main_rom]), .wdata(slot_wdata[slot_main_rom]),
        .wmask(slot_wmask[slot_main_rom]),
        .grant_done(grant_done[slot_main_rom]), .rdata(data_read)
    );

    // Only read/write slot, vram_sel picks the VRAM region
    slot_request #(
        .aw(17), .dw(16), .bank(bank_main), .offset(ram_offset), .use_vram_sel(1'b1)
    ) u_main_ram (
        .VB(VB), .rst(rst), .cs(main_ram_cs), .addr(main_ram_addr),
        .wr(!main_ram_rnw), .din(main_ram_din), .wrmask(main_ram_dsn),
        .vram_sel(main_ram_vram),
        .dout(main_ram_data), .ok(main_ram_ok), .pend(pend[slot_main_ram]),
        .full_addr(slot_addr[slot_main_ram]), .bank_out(slot_bank[slot_main_ram]),
        .rnw(slot_rnw[slot_main_ram]), .wdata(slot_wdata[slot_main_ram]),
        .wmask(slot_wmask[slot_main_ram]),
        .grant_done(grant_done[slot_main_ram]), .rdata(data_read)
    );

    slot_request #(.aw(20), .dw(32), .bank(bank_gfx), .offset(gfx_offset)) u_gfx (
        .VB(VB), .rst(rst), .cs(gfx_cs), .addr(gfx_addr),
        .wr(1'b0), .din(16'h0000), .wrmask(2'b11), .vram_sel(1'b0),
        .dout(gfx_data), .ok(gfx_ok), .pend(pend[slot_gfx]),
        .full_addr(slot_addr[slot_gfx]), .bank_out(slot_bank[slot_gfx]),
        .rnw(slot_rnw[slot_gfx]), .wdata(slot_wdata[slot_gfx]),
        .wmask(slot_wmask[slot_gfx]),
        .grant_done(grant_done[slot_gfx]), .rdata(data_read)
    );

    slot_request #(.aw(16), .dw(8), .bank(bank_sound), .offset(sound_offset)) u_sound (
        .VB(VB), .rst(rst), .cs(snd_cs), .addr(snd_addr),
        .wr(1'b0), .din(16'h0000), .wrmask(2'b11), .vram_sel(1'b0),
        .dout(snd_data), .ok(snd_ok), .pend(pend[slot_sound]),
        .full_addr(slot_addr[slot_sound]), .bank_out(slot_bank[slot_sound]),
        .rnw(slot_rnw[slot_sound]), .wdata(slot_wdata[slot_sound]),
        .wmask(slot_wmask[slot_sound]),
        .grant_done(grant_done[slot_sound]), .rdata(data_read)
    );

    slot_arbiter u_slot_arbiter (
        .VB(VB), .rst(rst), .downloading(downloading), .pend(pend),
        .addr0(slot_addr[0]), .addr1(slot_addr[1]),
        .addr2(slot_addr[2]), .addr3(slot_addr[3]),
        .bank0(slot_bank[0]), .bank1(slot_bank[1]),
        .bank2(slot_bank[2]), .bank3(slot_bank[3]),
        .rnw0(slot_rnw[0]), .rnw1(slot_rnw[1]), .rnw2(slot_rnw[2]), .rnw3(slot_rnw[3]),
        .wdata0(slot_wdata[0]), .wdata1(slot_wdata[1]),
        .wdata2(slot_wdata[2]), .wdata3(slot_wdata[3]),
        .wmask0(slot_wmask[0]), .wmask1(slot_wmask[1]),
        .wmask2(slot_wmask[2]), .wmask3(slot_wmask[3]),
        .grant_done(grant_done), .sdram_req(sdram_req), .sdram_addr(sdram_addr),
        .sdram_bank(sdram_bank), .sdram_rnw(sdram_rnw), .data_write(data_write),
        .sdram_wrmask(sdram_wrmask), .sdram_ack(sdram_ack), .data_rdy(data_rdy)
    );

    rom_download u_rom_download (
        .VB(VB), .rst(rst), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr),
        .sdram_ack(sdram_ack),
        .prog_addr(prog_addr), .prog_data(prog_data), .prog_mask(prog_mask),
        .prog_bank(prog_bank), .prog_we(prog_we)
    );

endmodule

// File: tests/sdram_mux_assertions.sv
module sdram_mux_assertions (
    input logic        VB,
    input logic        rst,
    input logic        req,
    input logic        ack,
    input logic [42:0] fields      // Address, bank, data and mask of the request
);
    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;   // Failed assertions so far

    // Request held until ack
    hold_req: assert property (@(posedge VB) disable iff (rst) req && !ack |=> req)
        else begin
            fails++;
            $error("Request dropped before ack");
        end

    stable_fields: assert property (
        @(posedge VB) disable iff (rst) req && !ack |=> $stable(fields)
    ) else begin
        fails++;
        $error("Request fields changed before ack");
    end

    release_req: assert property (@(posedge VB) disable iff (rst) req && ack |=> !req)
        else begin
            fails++;
            $error("Request still high after ack");
        end

endmodule

bind slot_arbiter sdram_mux_assertions u_arbiter_assertions (
    .VB(VB), .rst(rst), .req(sdram_req), .ack(sdram_ack),
    .fields({sdram_addr, sdram_bank, sdram_rnw, data_write, sdram_wrmask})
);

bind rom_download sdram_mux_assertions u_download_assertions (
    .VB(VB), .rst(rst), .req(prog_we), .ack(sdram_ack),
    .fields({9'd0, prog_addr, prog_data, prog_mask, prog_bank})
);

// File: tests/sdram_mux_checker.sv
module sdram_mux_checker (
    input logic        VB,
    input logic        rst,
    input logic        downloading,
    input logic        main_rom_cs,
    input logic [20:0] main_rom_addr,
    input logic [15:0] main_rom_data,
    input logic        main_rom_ok,
    input logic        main_ram_cs,
    input logic        main_ram_vram,
    input logic        main_ram_rnw,
    input logic [16:0] main_ram_addr,
    input logic [15:0] main_ram_din,
    input logic [1:0]  main_ram_dsn,
    input logic [15:0] main_ram_data,
    input logic        main_ram_ok,
    input logic        gfx_cs,
    input logic [19:0] gfx_addr,
    input logic [31:0] gfx_data,
    input logic        gfx_ok,
    input logic        snd_cs,
    input logic [15:0] snd_addr,
    input logic [7:0]  snd_data,
    input logic        snd_ok,
    input logic        sdram_req,
    input logic [21:0] sdram_addr,
    input logic [1:0]  sdram_bank,
    input logic        sdram_rnw,
    input logic [15:0] data_write,
    input logic [1:0]  sdram_wrmask,
    input logic [24:0] ioctl_addr,
    input logic [7:0]  ioctl_data,
    input logic [21:0] prog_addr,
    input logic [7:0]  prog_data,
    input logic [1:0]  prog_mask,
    input logic [1:0]  prog_bank,
    input logic        prog_we
);
    timeunit 1ns;
    timeprecision 1ps;

    int          errors = 0;
    int          hits = 0;
    logic [15:0] shadow [logic [23:0]];   // Expected SDRAM contents
    logic [3:0]  cs_v, ok_v;
    logic [3:0]  cs_q = '0;
    logic [3:0]  ok_q = '0;
    logic [3:0]  req_seen = '0;          // Slot reached the SDRAM since cs rose
    logic        req_q = 1'b0;
    logic        prog_q = 1'b0;
    logic        dl_q = 1'b0;

    assign cs_v = {snd_cs, gfx_cs, main_ram_cs, main_rom_cs};
    assign ok_v = {snd_ok, gfx_ok, main_ram_ok, main_rom_ok};

    function automatic logic [15:0] expect_fill(input logic [23:0] loc);
        logic [31:0] x;
        x = {8'h00, loc} * 32'h9e37_79b1;
        return x[31:16] ^ x[15:0];
    endfunction

    // Bank and word address for a slot access
    function automatic logic [23:0] expect_loc(input int slot, input logic [21:0] a,
                                               input logic vram);
        case (slot)
            0: return {2'd1, a};
            1: return {2'd1, (vram ? 22'h30_0000 : 22'h20_0000) + a};
            2: return {2'd2, a};
            default: return {2'd0, a};
        endcase
    endfunction

    function automatic logic [21:0] addr_of(input int slot);
        case (slot)
            0: return {1'b0, main_rom_addr};
            1: return {5'd0, main_ram_addr};
            2: return {2'd0, gfx_addr};
            default: return {6'd0, snd_addr};
        endcase
    endfunction

    function automatic logic [15:0] shadow_word(input logic [23:0] loc);
        if (shadow.exists(loc)) return shadow[loc];
        return expect_fill(loc);
    endfunction

    task automatic merge(input logic [23:0] loc, input logic [15:0] d, input logic [1:0] m);
        logic [15:0] old;
        old = shadow_word(loc);
        shadow[loc] = {m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]};
    endtask

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("MISMATCH %s %s: expected %h actual %h", sdram_mux_tb.test_name, what,
                 exp, act);
    endtask

    task automatic check_request();
        int          slot;
        logic [23:0] loc;
        slot = -1;
        for (int i = 3; i >= 0; i--) begin
            if (cs_v[i] && !ok_v[i] && !req_seen[i]) slot = i;   // Lowest waiting slot
        end
        if (dl_q) begin
            errors++;
            $display("Slot request reached the SDRAM while downloading");
        end
        if (slot < 0) begin
            errors++;
            $display("SDRAM request seen with no slot waiting for one");
            return;
        end
        req_seen[slot] = 1'b1;
        loc = expect_loc(slot, addr_of(slot), main_ram_vram);
        if ({sdram_bank, sdram_addr} != loc)
            mismatch("request bank/address", loc, {sdram_bank, sdram_addr});
        if (slot == 1 && !main_ram_rnw) begin
            if (sdram_rnw) mismatch("request rnw", 0, sdram_rnw);
            if (data_write != main_ram_din) mismatch("write data", main_ram_din, data_write);
            if (sdram_wrmask != main_ram_dsn) mismatch("write mask", main_ram_dsn, sdram_wrmask);
            merge(loc, main_ram_din, main_ram_dsn);
        end else if (!sdram_rnw) begin
            mismatch("request rnw", 1, sdram_rnw);
        end
    endtask

    task automatic check_program();
        logic [23:0] loc;
        logic [1:0]  m;
        if (ioctl_addr >= 25'h50_0000) loc = {2'd2, 22'(({1'b0, ioctl_addr} - 26'h50_0000) >> 1)};
        else if (ioctl_addr >= 25'h40_0000) loc = {2'd0, 22'((ioctl_addr - 25'h40_0000) >> 1)};
        else loc = {2'd1, 22'(ioctl_addr >> 1)};
        m = 2'b11;
        m[ioctl_addr[0]] = 1'b0;                // Odd byte goes to the upper half
        if ({prog_bank, prog_addr} != loc)
            mismatch("program bank/address", loc, {prog_bank, prog_addr});
        if (prog_mask != m) mismatch("program mask", m, prog_mask);
        if (prog_data != ioctl_data) mismatch("program data", ioctl_data, prog_data);
        merge(loc, {ioctl_data, ioctl_data}, m);
    endtask

    task automatic check_ok(input int i);
        logic [23:0] loc;
        logic [31:0] exp, act;
        if (!req_seen[i]) hits++;
        if (i == 1 && !main_ram_rnw) return;   // Write completion, no data
        loc = expect_loc(i, addr_of(i), main_ram_vram);
        exp = {shadow_word({loc[23:22], loc[21:0] + 22'd1}), shadow_word(loc)};
        case (i)
            0: begin act = {16'h0, main_rom_data}; exp = {16'h0, exp[15:0]}; end
            1: begin act = {16'h0, main_ram_data}; exp = {16'h0, exp[15:0]}; end
            2: act = gfx_data;
            default: begin act = {24'h0, snd_data}; exp = {24'h0, exp[7:0]}; end
        endcase
        if (act != exp) mismatch($sformatf("slot %0d read data", i), exp, act);
    endtask

    always @(posedge VB) begin
        if (!rst) begin
            for (int i = 0; i < 4; i++) begin
                if (cs_v[i] && !cs_q[i]) req_seen[i] = 1'b0;
            end
            if (sdram_req && !req_q) check_request();
            if (prog_we && !prog_q) check_program();
            for (int i = 0; i < 4; i++) begin
                if (ok_v[i] && !ok_q[i]) check_ok(i);
            end
        end
        cs_q   = cs_v;
        ok_q   = ok_v;
        req_q  = sdram_req;
        prog_q = prog_we;
        dl_q   = downloading;
    end

endmodule

// File: tests/sdram_mux_tb.sv
module sdram_mux_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int planned_accesses = 64;
    localparam int expected_hits    = 4;

    logic        VB;
    logic        rst;
    logic        downloading;
    logic        main_rom_cs, main_rom_ok;
    logic [20:0] main_rom_addr;
    logic [15:0] main_rom_data;
    logic        main_ram_cs, main_ram_vram, main_ram_rnw, main_ram_ok;
    logic [16:0] main_ram_addr;
    logic [15:0] main_ram_din, main_ram_data;
    logic [1:0]  main_ram_dsn;
    logic        gfx_cs, gfx_ok;
    logic [19:0] gfx_addr;
    logic [31:0] gfx_data;
    logic        snd_cs, snd_ok;
    logic [15:0] snd_addr;
    logic [7:0]  snd_data;
    logic        sdram_req, sdram_rnw, sdram_ack, data_rdy;
    logic [21:0] sdram_addr;
    logic [1:0]  sdram_bank, sdram_wrmask;
    logic [15:0] data_write;
    logic [31:0] data_read;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data, prog_data;
    logic        ioctl_wr, prog_we;
    logic [21:0] prog_addr;
    logic [1:0]  prog_mask, prog_bank;

    string       test_name = "reset";
    integer      seed = 32'h76ad;
    int          tb_errors = 0;
    int          assert_errors = 0;
    logic [3:0]  ok_v;

    // SDRAM model state
    logic [15:0] mem [logic [23:0]];
    int          m_state = 0;
    int          m_cnt;
    logic [1:0]  rd_bank;
    logic [21:0] rd_addr;

    assign ok_v = {snd_ok, gfx_ok, main_ram_ok, main_rom_ok};

    sdram_game_mux u_sdram_game_mux (.*);
    sdram_mux_checker u_checker (.*);

    initial VB = 1'b0;
    always #4 VB = ~VB;

    // Unwritten words come from a hash of bank and address
    function automatic logic [15:0] fill_word(input logic [1:0] b, input logic [21:0] a);
        logic [31:0] x;
        x = {8'h00, b, a} * 32'h9e37_79b1;
        return x[31:16] ^ x[15:0];
    endfunction

    function automatic logic [15:0] read_word(input logic [1:0] b, input logic [21:0] a);
        if (mem.exists({b, a})) return mem[{b, a}];
        return fill_word(b, a);
    endfunction

    task automatic write_word(input logic [1:0] b, input logic [21:0] a,
                              input logic [15:0] d, input logic [1:0] m);
        logic [15:0] old;
        old = read_word(b, a);
        mem[{b, a}] = {m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]};  // Mask active low
    endtask

    function automatic int rand_delay();
        return {$random(seed)} % 4 + 1;
    endfunction

    // SDRAM and program port model, one access at a time
    always @(negedge VB) begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        if (rst) begin
            m_state = 0;
        end else begin
            case (m_state)
                0: if (sdram_req || prog_we) begin
                    m_cnt   = rand_delay();
                    m_state = 1;
                end
                1: if (m_cnt > 1) begin
                    m_cnt--;
                end else begin
                    sdram_ack = 1'b1;
                    if (prog_we) begin
                        write_word(prog_bank, prog_addr, {prog_data, prog_data}, prog_mask);
                        m_state = 0;
                    end else begin
                        if (!sdram_rnw) begin
                            write_word(sdram_bank, sdram_addr, data_write, sdram_wrmask);
                        end
                        rd_bank = sdram_bank;
                        rd_addr = sdram_addr;
                        m_cnt   = rand_delay();
                        m_state = 2;
                    end
                end
                default: if (m_cnt > 1) begin
                    m_cnt--;
                end else begin
                    data_rdy  = 1'b1;
                    data_read = {read_word(rd_bank, rd_addr + 22'd1), read_word(rd_bank, rd_addr)};
                    m_state   = 0;
                end
            endcase
        end
    end

    task automatic set_slot(input int i, input logic v, input logic [21:0] a);
        case (i)
            0: begin main_rom_cs = v; main_rom_addr = a[20:0]; end
            1: begin main_ram_cs = v; main_ram_addr = a[16:0]; end
            2: begin gfx_cs = v; gfx_addr = a[19:0]; end
            default: begin snd_cs = v; snd_addr = a[15:0]; end
        endcase
    endtask

    task automatic finish_access(input int i);
        do @(negedge VB); while (!ok_v[i]);
        case (i)
            0: main_rom_cs = 1'b0;
            1: main_ram_cs = 1'b0;
            2: gfx_cs = 1'b0;
            default: snd_cs = 1'b0;
        endcase
        do @(negedge VB); while (ok_v[i]);
    endtask

    task automatic read_slot(input int i, input logic [21:0] a, input logic vram);
        @(negedge VB);
        main_ram_rnw  = 1'b1;
        main_ram_vram = vram;
        set_slot(i, 1'b1, a);
        finish_access(i);
    endtask

    task automatic write_ram(input logic [16:0] a, input logic [15:0] d,
                             input logic [1:0] dsn, input logic vram);
        @(negedge VB);
        main_ram_rnw  = 1'b0;
        main_ram_vram = vram;
        main_ram_din  = d;
        main_ram_dsn  = dsn;
        set_slot(1, 1'b1, {5'd0, a});
        finish_access(1);
    endtask

    task automatic load_byte(input logic [24:0] a, input logic [7:0] d);
        @(negedge VB);
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        @(negedge VB);
        ioctl_wr = 1'b0;
        while (!prog_we) @(negedge VB);
        while (prog_we) @(negedge VB);
    endtask

    initial begin
        rst = 1'b1;
        downloading = 1'b0;
        {main_rom_cs, main_ram_cs, gfx_cs, snd_cs, main_ram_vram} = '0;
        main_rom_addr = '0;
        main_ram_addr = '0;
        gfx_addr = '0;
        snd_addr = '0;
        main_ram_rnw = 1'b1;
        main_ram_din = '0;
        main_ram_dsn = 2'b11;
        sdram_ack = 1'b0;
        data_rdy = 1'b0;
        data_read = '0;
        ioctl_addr = '0;
        ioctl_data = '0;
        ioctl_wr = 1'b0;
        repeat (5) @(negedge VB);
        rst = 1'b0;

        test_name = "mapping_read";
        for (int n = 0; n < 8; n++) begin
            for (int i = 0; i < 4; i++) read_slot(i, $random(seed), n[0]);
        end

        test_name = "ram_write_read";
        write_ram(17'h0_1234, 16'ha5c3, 2'b10, 1'b0);
        read_slot(1, 22'h0_1234, 1'b0);
        write_ram(17'h1_0abc, 16'h5a3c, 2'b01, 1'b1);
        read_slot(1, 22'h1_0abc, 1'b1);
        write_ram(17'h0_0042, 16'hbeef, 2'b00, 1'b1);
        read_slot(1, 22'h0_0042, 1'b1);

        test_name = "hit";
        for (int i = 0; i < 4; i++) begin
            read_slot(i, 22'h777 + i, 1'b0);
            read_slot(i, 22'h777 + i, 1'b0);   // Same word again
        end

        test_name = "priority";
        for (int r = 0; r < 2; r++) begin
            @(negedge VB);
            main_ram_rnw = 1'b1;
            for (int i = 0; i < 4; i++) set_slot(i, 1'b1, 22'h100 + r * 16 + i);
            do @(negedge VB); while (ok_v != 4'hf);
            {main_rom_cs, main_ram_cs, gfx_cs, snd_cs} = '0;
            do @(negedge VB); while (ok_v != 4'h0);
        end

        test_name = "download";
        @(negedge VB);
        downloading = 1'b1;
        set_slot(3, 1'b1, 22'h10);     // Must wait until the loader is done
        load_byte(25'h00_0101, 8'h3c);
        load_byte(25'h40_0020, 8'h81);
        load_byte(25'h40_0021, 8'h7e);
        load_byte(25'h50_0006, 8'hd2);
        load_byte(25'h50_0007, 8'h2d);
        load_byte(25'h00_0100, 8'h96);
        @(negedge VB);
        downloading = 1'b0;
        finish_access(3);
        read_slot(0, 22'h80, 1'b0);
        read_slot(2, 22'h3, 1'b0);

        if (u_checker.hits != expected_hits) begin
            tb_errors++;
            $display("Hit count is %0d but %0d one-word hits were expected",
                     u_checker.hits, expected_hits);
        end
        assert_errors = u_sdram_game_mux.u_slot_arbiter.u_arbiter_assertions.fails
                      + u_sdram_game_mux.u_rom_download.u_download_assertions.fails;
        $display("Errors: %0d (checker %0d, testbench %0d, assertions %0d)",
                 u_checker.errors + tb_errors + assert_errors, u_checker.errors, tb_errors,
                 assert_errors);
        if (u_checker.errors + tb_errors + assert_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(planned_accesses * 40 * 8);
        $display("Timeout: the tests did not finish in time during %s", test_name);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: files.f
verilog/sdram_map_pkg.sv
verilog/slot_request.sv
verilog/slot_arbiter.sv
verilog/rom_download.sv
verilog/sdram_game_mux.sv
tests/sdram_mux_assertions.sv
tests/sdram_mux_checker.sv
tests/sdram_mux_tb.sv

// File: Bender.yml
package:
  name: sdram_game_mux

sources:
  - files:
      - verilog/sdram_map_pkg.sv
      - verilog/slot_request.sv
      - verilog/slot_arbiter.sv
      - verilog/rom_download.sv
      - verilog/sdram_game_mux.sv
  - target: test
    files:
      - tests/sdram_mux_assertions.sv
      - tests/sdram_mux_checker.sv
      - tests/sdram_mux_tb.sv
